/* logic/swarm_macros.svh */
`ifndef SWARM_MACROS_SVH
`define SWARM_MACROS_SVH

// Task field widths
`define TS_W              16
`define LOCALE_W          16
`define TTYPE_W           4
`define ARGS_W            32

// CQ slice of 8 slots
`define LOG_CQ_SLICE_SIZE 3
`define THREAD_W          2
`define CHILD_W           3
`define UNDO_ID_W         2

`define ABORT_RST_CYCLES  6
`define ENGINE_LAT        3

// Register map
`define REG_ADDR_W        4
`define REG_DATA_W        32
`define CORE_START        4'd0
`define CORE_N_DEQUEUES   4'd1
`define CORE_NUM_ENQ      4'd2
`define CORE_NUM_DEQ      4'd3
`define CORE_STATE        4'd4

`endif

/* logic/swarm_pkg.sv */
`include "swarm_macros.svh"

package swarm_pkg;

   typedef logic [`TS_W-1:0]              ts_t;
   typedef logic [`LOCALE_W-1:0]          locale_t;
   typedef logic [`TTYPE_W-1:0]           ttype_t;
   typedef logic [`ARGS_W-1:0]            args_t;

   typedef logic [`LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;
   typedef logic [`THREAD_W-1:0]          thread_id_t;
   typedef logic [`CHILD_W-1:0]           child_id_t;
   typedef logic [`UNDO_ID_W-1:0]         undo_id_t;

   typedef logic [`REG_ADDR_W-1:0]        reg_addr_t;
   typedef logic [`REG_DATA_W-1:0]        reg_data_t;
   typedef logic [31:0]                   undo_data_t;

   typedef struct packed {
      ts_t     ts;
      locale_t locale;
      ttype_t  ttype;
      args_t   args;
   } task_t;

   typedef struct packed {
      locale_t    addr;
      undo_data_t data;
   } undo_entry_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
      reg_data_t data;
   } reg_wr_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
   } reg_rd_req_t;

   typedef struct packed {
      logic      valid;
      reg_data_t data;
   } reg_rd_rsp_t;

   typedef enum logic [2:0] {
      NEXT_TASK,
      INFORM_CQ,
      START_CORE,
      WAIT_CORE,
      ABORT_TASK,
      FINISH_TASK
   } core_state_t;

endpackage

/* logic/app_engine.sv */
`timescale 1ns/1ps
`include "swarm_macros.svh"

module app_engine (
   input  logic                  clk,
   input  logic                  ap_rstn,
   input  logic                  ap_start,
   input  swarm_pkg::task_t      ap_task,
   output logic                  ap_child_valid,
   output swarm_pkg::task_t      ap_child,
   input  logic                  ap_child_ready,
   output logic                  ap_undo_valid,
   output swarm_pkg::undo_entry_t ap_undo,
   input  logic                  ap_undo_ready,
   output logic                  ap_done,
   output logic                  ap_idle
);

   localparam int LAT_W = $clog2(`ENGINE_LAT + 1);

   typedef enum logic [2:0] {
      E_IDLE,
      E_COMPUTE,
      E_CHILD,
      E_UNDO,
      E_DONE
   } eng_state_t;

   eng_state_t          eng_state;
   swarm_pkg::task_t    task_q;
   swarm_pkg::child_id_t idx;
   swarm_pkg::child_id_t n_children;
   swarm_pkg::child_id_t last_idx;
   logic [LAT_W-1:0]    lat_cnt;
   logic                has_undo;

   // Child count and undo request are encoded in the low argument bits
   assign n_children = task_q.args[2:0];
   assign last_idx   = n_children - swarm_pkg::child_id_t'(1);
   assign has_undo   = task_q.args[3];

   assign ap_child_valid  = (eng_state == E_CHILD);
   assign ap_child.ts     = task_q.ts + swarm_pkg::ts_t'(1) + swarm_pkg::ts_t'(idx);
   assign ap_child.locale = task_q.locale + swarm_pkg::locale_t'(idx);
   assign ap_child.ttype  = task_q.ttype;
   assign ap_child.args   = task_q.args >> 3;

   assign ap_undo_valid = (eng_state == E_UNDO);
   assign ap_undo.addr  = task_q.locale;
   assign ap_undo.data  = task_q.args;

   assign ap_done = (eng_state == E_DONE);
   assign ap_idle = (eng_state == E_IDLE);

   always_ff @(posedge clk) begin
      if (eng_state == E_IDLE && ap_start) begin
         task_q <= ap_task;
      end
   end

   always_ff @(posedge clk) begin
      if (!ap_rstn) begin
         eng_state <= E_IDLE;
         idx       <= '0;
         lat_cnt   <= '0;
      end else begin
         case (eng_state)
            E_IDLE: begin
               if (ap_start) begin
                  eng_state <= E_COMPUTE;
                  idx       <= '0;
                  lat_cnt   <= LAT_W'(`ENGINE_LAT - 1);
               end
            end
            E_COMPUTE: begin
               // Leaving at count one puts the first child ENGINE_LAT cycles after start
               if (lat_cnt == LAT_W'(1)) begin
                  if (n_children != '0) begin
                     eng_state <= E_CHILD;
                  end else begin
                     eng_state <= has_undo ? E_UNDO : E_DONE;
                  end
               end else begin
                  lat_cnt <= lat_cnt - LAT_W'(1);
               end
            end
            E_CHILD: begin
               if (ap_child_ready) begin
                  idx <= idx + swarm_pkg::child_id_t'(1);
                  if (idx == last_idx) begin
                     eng_state <= has_undo ? E_UNDO : E_DONE;
                  end
               end
            end
            E_UNDO: begin
               if (ap_undo_ready) begin
                  eng_state <= E_DONE;
               end
            end
            default: begin
               eng_state <= E_IDLE;
            end
         endcase
      end
   end

endmodule

/* logic/core_regs.sv */
`timescale 1ns/1ps
`include "swarm_macros.svh"

module core_regs (
   input  logic                   clk,
   input  logic                   rstn,
   input  swarm_pkg::reg_wr_t     reg_wr,
   input  swarm_pkg::reg_rd_req_t reg_rd_req,
   output swarm_pkg::reg_rd_rsp_t reg_rd_rsp,
   input  logic                   deq_fire,
   input  logic                   enq_fire,
   input  swarm_pkg::core_state_t state,
   output logic                   start,
   output logic                   deq_allowed
);

   swarm_pkg::reg_data_t deq_budget;
   swarm_pkg::reg_data_t num_enq;
   swarm_pkg::reg_data_t num_deq;
   swarm_pkg::reg_data_t rd_data;
   logic                 rd_valid;

   assign deq_allowed = (deq_budget != '0);
   assign reg_rd_rsp  = '{valid: rd_valid, data: rd_data};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start      <= 1'b0;
         deq_budget <= '1;
         num_enq    <= '0;
         num_deq    <= '0;
      end else begin
         if (reg_wr.valid && reg_wr.addr == `CORE_START) begin
            start <= reg_wr.data[0];
         end
         // A budget write wins over a dequeue in the same cycle
         if (reg_wr.valid && reg_wr.addr == `CORE_N_DEQUEUES) begin
            deq_budget <= reg_wr.data;
         end else if (deq_fire) begin
            deq_budget <= deq_budget - swarm_pkg::reg_data_t'(1);
         end
         if (enq_fire) begin
            num_enq <= num_enq + swarm_pkg::reg_data_t'(1);
         end
         if (deq_fire) begin
            num_deq <= num_deq + swarm_pkg::reg_data_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= reg_rd_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      case (reg_rd_req.addr)
         `CORE_START:      rd_data <= swarm_pkg::reg_data_t'(start);
         `CORE_N_DEQUEUES: rd_data <= deq_budget;
         `CORE_NUM_ENQ:    rd_data <= num_enq;
         `CORE_NUM_DEQ:    rd_data <= num_deq;
         `CORE_STATE:      rd_data <= swarm_pkg::reg_data_t'(state);
         default:          rd_data <= '0;
      endcase
   end

endmodule

/* logic/task_core.sv */
`timescale 1ns/1ps
`include "swarm_macros.svh"

module task_core (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              start,
   input  logic                              deq_allowed,

   // Dequeue from the CQ slice
   output logic                              task_arvalid,
   input  logic                              task_rvalid,
   input  swarm_pkg::task_t                  task_rdata,
   input  swarm_pkg::cq_slot_t               task_rslot,
   input  swarm_pkg::thread_id_t             task_rthread,

   output logic                              start_task_valid,
   input  logic                              start_task_ready,
   output swarm_pkg::cq_slot_t               start_task_slot,

   output logic                              finish_task_valid,
   input  logic                              finish_task_ready,
   output swarm_pkg::cq_slot_t               finish_task_slot,
   output swarm_pkg::thread_id_t             finish_task_thread,
   output swarm_pkg::child_id_t              finish_task_num_children,
   output logic                              finish_task_undo_log_write,

   input  logic [(1<<`LOG_CQ_SLICE_SIZE)-1:0] task_aborted,

   // Child enqueue
   output logic                              task_wvalid,
   output swarm_pkg::task_t                  task_wdata,
   input  logic                              task_wready,
   output swarm_pkg::child_id_t              task_child_id,

   output logic                              undo_log_valid,
   output swarm_pkg::undo_entry_t            undo_log_entry,
   output swarm_pkg::undo_id_t               undo_log_id,
   output swarm_pkg::cq_slot_t               undo_log_slot,
   input  logic                              undo_log_ready,

   // Engine side
   output logic                              ap_rstn,
   output logic                              ap_start,
   output swarm_pkg::task_t                  ap_task,
   input  logic                              ap_child_valid,
   input  swarm_pkg::task_t                  ap_child,
   output logic                              ap_child_ready,
   input  logic                              ap_undo_valid,
   input  swarm_pkg::undo_entry_t            ap_undo,
   output logic                              ap_undo_ready,
   input  logic                              ap_done,
   input  logic                              ap_idle,

   output logic                              deq_fire,
   output logic                              enq_fire,
   output swarm_pkg::core_state_t            state
);

   localparam int RST_W = $clog2(`ABORT_RST_CYCLES + 1);

   swarm_pkg::core_state_t state_next;
   swarm_pkg::cq_slot_t    cq_slot;
   swarm_pkg::thread_id_t  thread_id;
   swarm_pkg::task_t       task_in;
   swarm_pkg::child_id_t   child_id;
   logic [RST_W-1:0]       rst_cnt;
   logic                   abort_hit;
   logic                   abort_seen;
   logic                   abort_q;
   logic                   child_fire;
   logic                   undo_fire;

   assign task_arvalid = (state == swarm_pkg::NEXT_TASK) && start && deq_allowed;
   assign deq_fire     = task_arvalid && task_rvalid;
   assign enq_fire     = task_wvalid && task_wready;

   assign start_task_valid  = (state == swarm_pkg::INFORM_CQ);
   assign start_task_slot   = cq_slot;
   assign finish_task_valid = (state == swarm_pkg::FINISH_TASK) && !task_wvalid && !undo_log_valid;
   assign finish_task_slot  = cq_slot;
   assign finish_task_thread       = thread_id;
   assign finish_task_num_children = child_id;
   assign task_child_id = child_id;
   assign undo_log_slot = cq_slot;

   // Engine outputs are ignored while it sits in reset
   assign ap_rstn        = (rst_cnt == '0);
   assign ap_task        = task_in;
   assign ap_child_ready = !task_wvalid && ap_rstn;
   assign ap_undo_ready  = !undo_log_valid && ap_rstn;
   assign child_fire     = ap_child_valid && ap_child_ready;
   assign undo_fire      = ap_undo_valid && ap_undo_ready;

   assign abort_hit  = task_aborted[cq_slot];
   assign abort_seen = abort_hit && ((state == swarm_pkg::INFORM_CQ) ||
                                     (state == swarm_pkg::WAIT_CORE && !ap_done));

   always_comb begin
      state_next = state;
      case (state)
         swarm_pkg::NEXT_TASK: begin
            if (deq_fire) state_next = swarm_pkg::INFORM_CQ;
         end
         swarm_pkg::INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = (abort_q || abort_hit) ? swarm_pkg::FINISH_TASK
                                                   : swarm_pkg::START_CORE;
            end
         end
         swarm_pkg::START_CORE: begin
            state_next = swarm_pkg::WAIT_CORE;
         end
         swarm_pkg::WAIT_CORE: begin
            if (rst_cnt == RST_W'(1)) begin
               state_next = swarm_pkg::ABORT_TASK;
            end else if (!abort_q && ap_done) begin
               state_next = swarm_pkg::FINISH_TASK;
            end
         end
         swarm_pkg::ABORT_TASK: begin
            if (ap_idle) state_next = swarm_pkg::FINISH_TASK;
         end
         swarm_pkg::FINISH_TASK: begin
            if (finish_task_valid && finish_task_ready) state_next = swarm_pkg::NEXT_TASK;
         end
         default: state_next = swarm_pkg::NEXT_TASK;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= swarm_pkg::NEXT_TASK;
         ap_start <= 1'b0;
         abort_q  <= 1'b0;
         rst_cnt  <= '0;
      end else begin
         state    <= state_next;
         ap_start <= (state == swarm_pkg::START_CORE);
         if (state == swarm_pkg::NEXT_TASK) begin
            abort_q <= 1'b0;
         end else if (abort_seen) begin
            abort_q <= 1'b1;
         end
         // Engine reset window counts down to zero
         if (state == swarm_pkg::WAIT_CORE && abort_q && rst_cnt == '0) begin
            rst_cnt <= RST_W'(`ABORT_RST_CYCLES);
         end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - RST_W'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (deq_fire) begin
         cq_slot   <= task_rslot;
         thread_id <= task_rthread;
         task_in   <= task_rdata;
      end
      if (child_fire) task_wdata <= ap_child;
      if (undo_fire) undo_log_entry <= ap_undo;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid    <= 1'b0;
         undo_log_valid <= 1'b0;
         undo_log_id    <= '0;
         child_id       <= '0;
         finish_task_undo_log_write <= 1'b0;
      end else begin
         // Pending enqueue is dropped on abort
         if (child_fire) begin
            task_wvalid <= 1'b1;
         end else if (task_wready || state == swarm_pkg::ABORT_TASK) begin
            task_wvalid <= 1'b0;
         end
         if (undo_fire) begin
            undo_log_valid <= 1'b1;
         end else if (undo_log_ready) begin
            undo_log_valid <= 1'b0;
         end
         if (finish_task_valid) begin
            undo_log_id <= '0;
         end else if (undo_log_valid && undo_log_ready) begin
            undo_log_id <= undo_log_id + swarm_pkg::undo_id_t'(1);
         end
         if (state == swarm_pkg::NEXT_TASK) begin
            child_id <= '0;
         end else if (enq_fire) begin
            child_id <= child_id + swarm_pkg::child_id_t'(1);
         end
         if (deq_fire) begin
            finish_task_undo_log_write <= 1'b0;
         end else if (undo_fire) begin
            finish_task_undo_log_write <= 1'b1;
         end
      end
   end

endmodule

/* logic/task_tile.sv */
`timescale 1ns/1ps
`include "swarm_macros.svh"

module task_tile (
   input  logic                              clk,
   input  logic                              rstn,
   output logic                              task_arvalid,
   input  logic                              task_rvalid,
   input  swarm_pkg::task_t                  task_rdata,
   input  swarm_pkg::cq_slot_t               task_rslot,
   input  swarm_pkg::thread_id_t             task_rthread,
   output logic                              start_task_valid,
   input  logic                              start_task_ready,
   output swarm_pkg::cq_slot_t               start_task_slot,
   output logic                              finish_task_valid,
   input  logic                              finish_task_ready,
   output swarm_pkg::cq_slot_t               finish_task_slot,
   output swarm_pkg::thread_id_t             finish_task_thread,
   output swarm_pkg::child_id_t              finish_task_num_children,
   output logic                              finish_task_undo_log_write,
   input  logic [(1<<`LOG_CQ_SLICE_SIZE)-1:0] task_aborted,
   output logic                              task_wvalid,
   output swarm_pkg::task_t                  task_wdata,
   input  logic                              task_wready,
   output swarm_pkg::child_id_t              task_child_id,
   output logic                              undo_log_valid,
   output swarm_pkg::undo_entry_t            undo_log_entry,
   output swarm_pkg::undo_id_t               undo_log_id,
   output swarm_pkg::cq_slot_t               undo_log_slot,
   input  logic                              undo_log_ready,
   input  swarm_pkg::reg_wr_t                reg_wr,
   input  swarm_pkg::reg_rd_req_t            reg_rd_req,
   output swarm_pkg::reg_rd_rsp_t            reg_rd_rsp
);

   // Core to engine
   logic                   ap_rstn;
   logic                   ap_start;
   swarm_pkg::task_t       ap_task;
   logic                   ap_child_valid;
   swarm_pkg::task_t       ap_child;
   logic                   ap_child_ready;
   logic                   ap_undo_valid;
   swarm_pkg::undo_entry_t ap_undo;
   logic                   ap_undo_ready;
   logic                   ap_done;
   logic                   ap_idle;

   // Core to register file
   logic                   start;
   logic                   deq_allowed;
   logic                   deq_fire;
   logic                   enq_fire;
   swarm_pkg::core_state_t state;

   task_core i_task_core (.*);

   app_engine i_app_engine (.*);

   core_regs i_core_regs (.*);

endmodule

/* testbench/tb_task_tile.sv */
`timescale 1ns/1ps
`include "swarm_macros.svh"

module tb_task_tile;

   localparam int TIMEOUT_CYCLES = 3000;

   logic                              clk;
   logic                              rstn;
   logic                              task_arvalid;
   logic                              task_rvalid;
   swarm_pkg::task_t                  task_rdata;
   swarm_pkg::cq_slot_t               task_rslot;
   swarm_pkg::thread_id_t             task_rthread;
   logic                              start_task_valid;
   logic                              start_task_ready;
   swarm_pkg::cq_slot_t               start_task_slot;
   logic                              finish_task_valid;
   logic                              finish_task_ready;
   swarm_pkg::cq_slot_t               finish_task_slot;
   swarm_pkg::thread_id_t             finish_task_thread;
   swarm_pkg::child_id_t              finish_task_num_children;
   logic                              finish_task_undo_log_write;
   logic [(1<<`LOG_CQ_SLICE_SIZE)-1:0] task_aborted;
   logic                              task_wvalid;
   swarm_pkg::task_t                  task_wdata;
   logic                              task_wready;
   swarm_pkg::child_id_t              task_child_id;
   logic                              undo_log_valid;
   swarm_pkg::undo_entry_t            undo_log_entry;
   swarm_pkg::undo_id_t               undo_log_id;
   swarm_pkg::cq_slot_t               undo_log_slot;
   logic                              undo_log_ready;
   swarm_pkg::reg_wr_t                reg_wr;
   swarm_pkg::reg_rd_req_t            reg_rd_req;
   swarm_pkg::reg_rd_rsp_t            reg_rd_rsp;

   // CQ model state
   swarm_pkg::task_t       cq_q[$];
   int unsigned            slot_cnt;
   logic [31:0]            lcg_state;
   int                     wready_mode;
   int                     cycles;
   int                     checks;
   int                     errors;

   // Observed handshakes
   int                     deq_count;
   int                     start_count;
   int                     enq_count;
   int                     finish_count;
   int                     enq_at_finish;
   swarm_pkg::cq_slot_t    deq_slot;
   swarm_pkg::thread_id_t  deq_thread;
   swarm_pkg::cq_slot_t    start_slot;
   swarm_pkg::cq_slot_t    fin_slot;
   swarm_pkg::thread_id_t  fin_thread;
   swarm_pkg::child_id_t   fin_children;
   logic                   fin_undo;
   swarm_pkg::task_t       enq_log[$];
   swarm_pkg::child_id_t   enq_id_log[$];
   swarm_pkg::undo_entry_t undo_log[$];
   swarm_pkg::undo_id_t    undo_id_log[$];
   swarm_pkg::cq_slot_t    undo_slot_log[$];

   task_tile i_dut (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic swarm_pkg::task_t make_task(input swarm_pkg::ts_t ts,
                                                  input swarm_pkg::locale_t locale,
                                                  input swarm_pkg::ttype_t ttype,
                                                  input swarm_pkg::args_t args);
      swarm_pkg::task_t t;
      t.ts     = ts;
      t.locale = locale;
      t.ttype  = ttype;
      t.args   = args;
      return t;
   endfunction

   // Child i of a parent task with 16-bit fields wrapping
   function automatic swarm_pkg::task_t expected_child(input swarm_pkg::task_t parent,
                                                       input int i);
      swarm_pkg::task_t c;
      c.ts     = parent.ts + swarm_pkg::ts_t'(1 + i);
      c.locale = parent.locale + swarm_pkg::locale_t'(i);
      c.ttype  = parent.ttype;
      c.args   = parent.args >> 3;
      return c;
   endfunction

   // CQ model offers the queue head while the core asks for a task
   always @(posedge clk) begin : cq_drive
      logic                  have_task;
      swarm_pkg::task_t      head;
      swarm_pkg::cq_slot_t   head_slot;
      swarm_pkg::thread_id_t head_thread;
      int                    mode;
      have_task   = (cq_q.size() > 0);
      head        = '0;
      if (have_task) begin
         head = cq_q[0];
      end
      head_slot   = swarm_pkg::cq_slot_t'(slot_cnt);
      head_thread = swarm_pkg::thread_id_t'(slot_cnt / 2);
      mode        = wready_mode;
      lcg_state   = lcg_next(lcg_state);
      #1;
      task_rvalid  = task_arvalid && have_task;
      task_rdata   = head;
      task_rslot   = head_slot;
      task_rthread = head_thread;
      case (mode)
         0:       task_wready = 1'b1;
         1:       task_wready = (lcg_state[17:16] != 2'b00);
         default: task_wready = 1'b0;
      endcase
   end

   // Handshakes are sampled mid-cycle where all signals are settled
   always @(negedge clk) begin
      if (rstn) begin
         if (task_arvalid && task_rvalid) begin
            deq_count++;
            deq_slot   = task_rslot;
            deq_thread = task_rthread;
            cq_q.delete(0);
            slot_cnt++;
         end
         if (start_task_valid && start_task_ready) begin
            start_count++;
            start_slot = start_task_slot;
         end
         if (task_wvalid && task_wready) begin
            enq_count++;
            enq_log.push_back(task_wdata);
            enq_id_log.push_back(task_child_id);
         end
         if (undo_log_valid && undo_log_ready) begin
            undo_log.push_back(undo_log_entry);
            undo_id_log.push_back(undo_log_id);
            undo_slot_log.push_back(undo_log_slot);
         end
         if (finish_task_valid && finish_task_ready) begin
            finish_count++;
            fin_slot      = finish_task_slot;
            fin_thread    = finish_task_thread;
            fin_children  = finish_task_num_children;
            fin_undo      = finish_task_undo_log_write;
            enq_at_finish = enq_log.size();
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("test failed");
         $finish;
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic check_eq(input string name, input logic [67:0] got,
                           input logic [67:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic clear_logs();
      start_count = 0;
      enq_log.delete();
      enq_id_log.delete();
      undo_log.delete();
      undo_id_log.delete();
      undo_slot_log.delete();
   endtask

   task automatic reg_write(input swarm_pkg::reg_addr_t addr, input swarm_pkg::reg_data_t data);
      reg_wr.valid = 1'b1;
      reg_wr.addr  = addr;
      reg_wr.data  = data;
      tick();
      reg_wr = '0;
   endtask

   task automatic reg_read(input swarm_pkg::reg_addr_t addr, output swarm_pkg::reg_data_t data);
      reg_rd_req.valid = 1'b1;
      reg_rd_req.addr  = addr;
      tick();
      reg_rd_req = '0;
      checks++;
      assert (reg_rd_rsp.valid) else begin
         errors++;
         $display("No register read response one cycle after a read of address %0d", addr);
      end
      data = reg_rd_rsp.data;
   endtask

   task automatic wait_finish(input int target);
      while (finish_count < target) begin
         tick();
      end
   endtask

   task automatic test_registers();
      swarm_pkg::reg_data_t rd;
      reg_read(`CORE_STATE, rd);
      check_eq("CORE_STATE", rd, swarm_pkg::NEXT_TASK);
      repeat (3) begin
         tick();
         check_eq("task_arvalid", task_arvalid, 1'b0);
      end
      reg_write(`CORE_N_DEQUEUES, 32'h0000_0123);
      reg_read(`CORE_N_DEQUEUES, rd);
      check_eq("CORE_N_DEQUEUES", rd, 32'h0000_0123);
      reg_write(`CORE_START, 32'h1);
      check_eq("task_arvalid", task_arvalid, 1'b1);
   endtask

   task automatic test_plain_task();
      int fin0;
      clear_logs();
      fin0 = finish_count;
      cq_q.push_back(make_task(16'h0100, 16'h0040, 4'h3, 32'h0));
      wait_finish(fin0 + 1);
      check_eq("start count", start_count, 1);
      check_eq("start_task_slot", start_slot, deq_slot);
      check_eq("finish_task_slot", fin_slot, deq_slot);
      check_eq("finish_task_thread", fin_thread, deq_thread);
      check_eq("finish_task_num_children", fin_children, 0);
      check_eq("finish_task_undo_log_write", fin_undo, 1'b0);
      check_eq("enqueue count", enq_log.size(), 0);
      check_eq("undo write count", undo_log.size(), 0);
   endtask

   task automatic test_children();
      swarm_pkg::task_t     t;
      swarm_pkg::reg_data_t enq0;
      swarm_pkg::reg_data_t enq1;
      int                   fin0;
      int                   i;
      clear_logs();
      reg_read(`CORE_NUM_ENQ, enq0);
      wready_mode = 1;
      fin0 = finish_count;
      t = make_task(16'h1000, 16'hFFFE, 4'h9, 32'hABCD_0005);
      cq_q.push_back(t);
      wait_finish(fin0 + 1);
      wready_mode = 0;
      check_eq("enqueue count", enq_log.size(), 5);
      for (i = 0; i < enq_log.size() && i < 5; i++) begin
         check_eq("task_wdata", enq_log[i], expected_child(t, i));
         check_eq("task_child_id", enq_id_log[i], i);
      end
      check_eq("finish_task_slot", fin_slot, deq_slot);
      check_eq("finish_task_num_children", fin_children, 5);
      check_eq("enqueues before finish", enq_at_finish, 5);
      reg_read(`CORE_NUM_ENQ, enq1);
      check_eq("CORE_NUM_ENQ", enq1, enq0 + 5);
   endtask

   task automatic test_undo();
      swarm_pkg::task_t t;
      int               fin0;
      clear_logs();
      fin0 = finish_count;
      // Two children plus an undo entry
      t = make_task(16'h2200, 16'h0777, 4'h1, 32'h5A5A_000A);
      cq_q.push_back(t);
      wait_finish(fin0 + 1);
      check_eq("enqueue count", enq_log.size(), 2);
      check_eq("undo write count", undo_log.size(), 1);
      if (undo_log.size() > 0) begin
         check_eq("undo_log_entry.addr", undo_log[0].addr, t.locale);
         check_eq("undo_log_entry.data", undo_log[0].data, t.args);
         check_eq("undo_log_id", undo_id_log[0], 0);
         check_eq("undo_log_slot", undo_slot_log[0], deq_slot);
      end
      check_eq("finish_task_slot", fin_slot, deq_slot);
      check_eq("finish_task_thread", fin_thread, deq_thread);
      check_eq("finish_task_num_children", fin_children, 2);
      check_eq("finish_task_undo_log_write", fin_undo, 1'b1);
   endtask

   task automatic test_abort();
      swarm_pkg::task_t t;
      int               fin0;
      int               enq_after;
      int               i;
      clear_logs();
      wready_mode = 2;
      fin0 = finish_count;
      cq_q.push_back(make_task(16'h3000, 16'h0010, 4'h2, 32'h0000_0007));
      while (!task_wvalid) begin
         tick();
      end
      task_aborted = '0;
      task_aborted[deq_slot] = 1'b1;
      wait_finish(fin0 + 1);
      tick();
      task_aborted = '0;
      wready_mode = 0;
      check_eq("finish_task_slot", fin_slot, deq_slot);
      check_eq("finish_task_num_children", fin_children, enq_at_finish);
      enq_after = enq_count;
      repeat (20) tick();
      check_eq("enqueues after aborted finish", enq_count - enq_after, 0);

      // A normal task runs after the abort
      clear_logs();
      fin0 = finish_count;
      t = make_task(16'h4000, 16'h0100, 4'h6, 32'h0000_0102);
      cq_q.push_back(t);
      wait_finish(fin0 + 1);
      check_eq("enqueue count", enq_log.size(), 2);
      for (i = 0; i < enq_log.size() && i < 2; i++) begin
         check_eq("task_wdata", enq_log[i], expected_child(t, i));
      end
      check_eq("finish_task_slot", fin_slot, deq_slot);
      check_eq("finish_task_num_children", fin_children, 2);
   endtask

   task automatic test_budget();
      swarm_pkg::reg_data_t deq0;
      swarm_pkg::reg_data_t deq1;
      int                   deq_start;
      int                   fin0;
      reg_read(`CORE_NUM_DEQ, deq0);
      reg_write(`CORE_N_DEQUEUES, 32'd2);
      deq_start = deq_count;
      fin0 = finish_count;
      repeat (3) begin
         cq_q.push_back(make_task(16'h5000, 16'h0200, 4'h4, 32'h0));
      end
      wait_finish(fin0 + 2);
      repeat (30) tick();
      check_eq("dequeue count", deq_count - deq_start, 2);
      check_eq("finish count", finish_count - fin0, 2);
      check_eq("tasks left in CQ", cq_q.size(), 1);
      check_eq("task_arvalid", task_arvalid, 1'b0);
      reg_read(`CORE_NUM_DEQ, deq1);
      check_eq("CORE_NUM_DEQ", deq1, deq0 + 2);
   endtask

   initial begin
      rstn              = 1'b0;
      clk               = 1'b0;
      task_rvalid       = 1'b0;
      task_rdata        = '0;
      task_rslot        = '0;
      task_rthread      = '0;
      start_task_ready  = 1'b1;
      finish_task_ready = 1'b1;
      task_aborted      = '0;
      task_wready       = 1'b1;
      undo_log_ready    = 1'b1;
      reg_wr            = '0;
      reg_rd_req        = '0;
      slot_cnt          = 0;
      lcg_state         = 32'd12930;
      wready_mode       = 0;
      cycles            = 0;
      checks            = 0;
      errors            = 0;
      deq_count         = 0;
      start_count       = 0;
      enq_count         = 0;
      finish_count      = 0;
      enq_at_finish     = 0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;

      test_registers();
      test_plain_task();
      test_children();
      test_undo();
      test_abort();
      test_budget();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+logic
logic/swarm_pkg.sv
logic/app_engine.sv
logic/core_regs.sv
logic/task_core.sv
logic/task_tile.sv
testbench/tb_task_tile.sv
